// ==== common/board_config.svh ====
// Board configuration macros: clock, baud divisor, pad count, LED pin, FIFO, reset and blink

`ifndef BOARD_CONFIG_SVH
`define BOARD_CONFIG_SVH

// Nominal system clock of the board in Hz
`define CLK_HZ 12_000_000

// Clock cycles per serial bit
`define BAUD_DIV 16

// Tristate GPIO pads driven by the pad controller
`define N_PADS 6

// Pin index of the LED pin, one above the last pad
`define PIN_LED 6

// Receive FIFO entries, power of two
`define FIFO_DEPTH 4

// Cycles the internal reset is held once the board reset releases
`define RESET_COUNT 20

// Cycles per blink half-period
`define BLINK_DIV 64

`endif

// ==== common/board_pkg.sv ====
// Package board_pkg: command byte union, received byte struct, pad state struct, opcodes

package board_pkg;

`include "board_config.svh"

	// Opcodes held in the top two bits of every command byte
	localparam logic [1:0] OP_PIN_OUT  = 2'd0;
	localparam logic [1:0] OP_PIN_OE   = 2'd1;
	localparam logic [1:0] OP_MASK_OUT = 2'd2;
	localparam logic [1:0] OP_MASK_OE  = 2'd3;

	// Single pin view: one pad (or the LED pin) gets one bit
	typedef struct packed {
		logic [1:0] op;
		logic [2:0] pin;
		logic       value;
		logic [1:0] unused;
	} cmd_pin_t;

	// Mask view: all pads at once, LED pin untouched
	typedef struct packed {
		logic [1:0]         op;
		logic [`N_PADS-1:0] mask;
	} cmd_mask_t;

	// One command byte, decoded through either view depending on op
	typedef union packed {
		cmd_pin_t  pin;
		cmd_mask_t mask;
	} cmd_byte_t;

	// Byte as it leaves the receiver, with its stop bit check
	typedef struct packed {
		logic       ferr;
		logic [7:0] data;
	} rx_byte_t;

	// Output and enable for every pad plus the LED pin
	typedef struct packed {
		logic [`N_PADS:0] padout;
		logic [`N_PADS:0] padoe;
	} pad_state_t;

endpackage

// ==== hdl/fpga_reset.sv ====
// Module fpga_reset: reset synchronizer and release delay counter

`timescale 1ns/1ps

`include "board_config.svh"

module fpga_reset (
	input  logic clk_sys,
	input  logic rst_n,
	output logic sys_rst_n
);

	localparam int W_CNT = $clog2(`RESET_COUNT + 1);
	localparam logic [W_CNT-1:0] CNT_LOAD = W_CNT'(`RESET_COUNT);

	logic [1:0]       rst_sync;
	logic [W_CNT-1:0] count;

	// Board reset is sampled directly so assertion takes effect on the first low edge;
	// only the release goes through the synchronizer and the counter
	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			rst_sync  <= 2'b00;
			count     <= CNT_LOAD;
			sys_rst_n <= 1'b0;
		end else begin
			rst_sync <= {rst_sync[0], 1'b1};
			// Hold the counter loaded until release is seen through both stages
			if (!rst_sync[1]) begin
				count <= CNT_LOAD;
			end else if (count != '0) begin
				count <= count - 1'b1;
			end
			sys_rst_n <= rst_sync[1] && (count == '0);
		end
	end

endmodule

// ==== uart/uart_rx.sv ====
// Module uart_rx: oversampled 8N1 serial receiver with stop bit framing check

`timescale 1ns/1ps

`include "board_config.svh"

module uart_rx import board_pkg::*; (
	input  logic     clk_sys,
	input  logic     rst_n,
	input  logic     rx,
	output logic     rx_valid,
	output rx_byte_t rx_data
);

	localparam int W_DIV = $clog2(`BAUD_DIV);
	localparam logic [W_DIV-1:0] HALF_BIT = W_DIV'(`BAUD_DIV / 2 - 1);
	localparam logic [W_DIV-1:0] FULL_BIT = W_DIV'(`BAUD_DIV - 1);

	localparam logic [2:0] S_IDLE  = 3'd0;
	localparam logic [2:0] S_START = 3'd1;
	localparam logic [2:0] S_DATA  = 3'd2;
	localparam logic [2:0] S_STOP  = 3'd3;
	localparam logic [2:0] S_TAIL  = 3'd4;

	logic [1:0]       rx_sync;
	logic             rx_prev;
	logic [2:0]       state;
	logic [W_DIV-1:0] div_cnt;
	logic [2:0]       bit_cnt;
	logic [7:0]       shift;
	logic             ferr;

	// Line idles high, so the synchronizer resets to ones
	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			rx_sync <= 2'b11;
			rx_prev <= 1'b1;
		end else begin
			rx_sync <= {rx_sync[0], rx};
			rx_prev <= rx_sync[1];
		end
	end

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			state    <= S_IDLE;
			div_cnt  <= '0;
			bit_cnt  <= '0;
			rx_valid <= 1'b0;
		end else begin
			rx_valid <= 1'b0;
			if (div_cnt != '0)
				div_cnt <= div_cnt - 1'b1;
			case (state)
				S_IDLE: if (rx_prev && !rx_sync[1]) begin
					state   <= S_START;
					div_cnt <= HALF_BIT;
				end
				// Middle of the start bit; a glitch that went back high is dropped
				S_START: if (div_cnt == '0) begin
					if (rx_sync[1]) begin
						state <= S_IDLE;
					end else begin
						state   <= S_DATA;
						div_cnt <= FULL_BIT;
						bit_cnt <= '0;
					end
				end
				S_DATA: if (div_cnt == '0) begin
					div_cnt <= FULL_BIT;
					bit_cnt <= bit_cnt + 1'b1;
					if (bit_cnt == 3'd7)
						state <= S_STOP;
				end
				S_STOP: if (div_cnt == '0) begin
					state   <= S_TAIL;
					div_cnt <= HALF_BIT;
				end
				// Report the byte half a bit after the stop sample
				S_TAIL: if (div_cnt == '0) begin
					state    <= S_IDLE;
					rx_valid <= 1'b1;
				end
				default: state <= S_IDLE;
			endcase
		end
	end

	// Data arrives LSB first
	always_ff @(posedge clk_sys) begin
		if (state == S_DATA && div_cnt == '0)
			shift <= {rx_sync[1], shift[7:1]};
		if (state == S_STOP && div_cnt == '0)
			ferr <= !rx_sync[1];
	end

	assign rx_data.data = shift;
	assign rx_data.ferr = ferr;

endmodule

// ==== uart/byte_fifo.sv ====
// Module byte_fifo: synchronous show-ahead FIFO of received bytes

`timescale 1ns/1ps

module byte_fifo import board_pkg::*; #(
	parameter int DEPTH = 4
) (
	input  logic     clk_sys,
	input  logic     rst_n,
	input  logic     push,
	input  rx_byte_t wdata,
	input  logic     pop,
	output rx_byte_t rdata,
	output logic     empty,
	output logic     full
);

	localparam int W_PTR = $clog2(DEPTH);

	rx_byte_t         mem [DEPTH];
	logic [W_PTR-1:0] wr_ptr;
	logic [W_PTR-1:0] rd_ptr;
	logic [W_PTR:0]   count;
	logic             do_push;
	logic             do_pop;

	// Push while full and pop while empty are both ignored
	assign do_push = push && !full;
	assign do_pop  = pop && !empty;

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			// Pointers wrap on their own since DEPTH is a power of two
			if (do_push)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= rd_ptr + 1'b1;
			case ({do_push, do_pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	always_ff @(posedge clk_sys) begin
		if (do_push)
			mem[wr_ptr] <= wdata;
	end

	// Head entry is visible without a read cycle
	assign rdata = mem[rd_ptr];
	assign empty = (count == '0);
	assign full  = (count == (W_PTR + 1)'(DEPTH));

endmodule

// ==== hdl/pad_ctrl.sv ====
// Module pad_ctrl: command decoder, pad output and enable registers, tristate pad drivers

`timescale 1ns/1ps

`include "board_config.svh"

module pad_ctrl import board_pkg::*; (
	input  logic               clk_sys,
	input  logic               rst_n,
	input  logic               empty,
	input  rx_byte_t           rdata,
	output logic               pop,
	inout  wire [`N_PADS-1:0]  gpio,
	output pad_state_t         pad_state
);

	localparam int N_PINS = `N_PADS + 1;

	cmd_byte_t         cmd;
	logic [N_PINS-1:0] padout;
	logic [N_PINS-1:0] padoe;

	// Take every byte as soon as the FIFO shows one
	assign pop = !empty;
	assign cmd = rdata.data;

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			padout <= '0;
			padoe  <= '0;
		end else if (pop && !rdata.ferr) begin
			case (cmd.pin.op)
				OP_PIN_OUT: begin
					// Pin index 7 has no register behind it
					if (cmd.pin.pin < N_PINS)
						padout[cmd.pin.pin] <= cmd.pin.value;
				end
				OP_PIN_OE: begin
					if (cmd.pin.pin < N_PINS)
						padoe[cmd.pin.pin] <= cmd.pin.value;
				end
				// Mask writes cover the pads only, LED pin keeps its state
				OP_MASK_OUT: padout[`N_PADS-1:0] <= cmd.mask.mask;
				OP_MASK_OE:  padoe[`N_PADS-1:0]  <= cmd.mask.mask;
				default: begin
					padout <= padout;
					padoe  <= padoe;
				end
			endcase
		end
	end

	// Tristate buffers, released to high-Z when not enabled
	for (genvar i = 0; i < `N_PADS; i++) begin : g_pad
		assign gpio[i] = padoe[i] ? padout[i] : 1'bz;
	end

	assign pad_state.padout = padout;
	assign pad_state.padoe  = padoe;

endmodule

// ==== hdl/blinky.sv ====
// Module blinky: clock divider toggling the alive LED

`timescale 1ns/1ps

`include "board_config.svh"

module blinky (
	input  logic clk_sys,
	input  logic rst_n,
	output logic blink
);

	localparam int W_CNT = $clog2(`BLINK_DIV);
	localparam logic [W_CNT-1:0] CNT_LAST = W_CNT'(`BLINK_DIV - 1);

	logic [W_CNT-1:0] count;

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			count <= '0;
			blink <= 1'b0;
		end else if (count == CNT_LAST) begin
			// End of a half-period
			count <= '0;
			blink <= !blink;
		end else begin
			count <= count + 1'b1;
		end
	end

endmodule

// ==== hdl/board_top.sv ====
// Module board_top: board top level with reset, UART receiver, FIFO, pad controller, blinker, LEDs

`timescale 1ns/1ps

`include "board_config.svh"

module board_top import board_pkg::*; (
	input  logic              clk_sys,
	input  logic              rst_n,
	input  logic              uart_rx,
	inout  wire [`N_PADS-1:0] gpio,
	output logic [7:0]        led
);

	logic       sys_rst_n;
	logic       rx_valid;
	rx_byte_t   rx_data;
	rx_byte_t   fifo_rdata;
	logic       fifo_empty;
	logic       fifo_pop;
	pad_state_t pad_state;
	logic       blink;
	logic       rx_line_n;

	// Internal reset, released a fixed delay after the board reset
	fpga_reset i_fpga_reset (
		.clk_sys   (clk_sys),
		.rst_n     (rst_n),
		.sys_rst_n (sys_rst_n)
	);

	uart_rx i_uart_rx (
		.clk_sys  (clk_sys),
		.rst_n    (sys_rst_n),
		.rx       (uart_rx),
		.rx_valid (rx_valid),
		.rx_data  (rx_data)
	);

	byte_fifo #(
		.DEPTH (`FIFO_DEPTH)
	) i_byte_fifo (
		.clk_sys (clk_sys),
		.rst_n   (sys_rst_n),
		.push    (rx_valid),
		.wdata   (rx_data),
		.pop     (fifo_pop),
		.rdata   (fifo_rdata),
		.empty   (fifo_empty),
		.full    (/* unused */)
	);

	pad_ctrl i_pad_ctrl (
		.clk_sys   (clk_sys),
		.rst_n     (sys_rst_n),
		.empty     (fifo_empty),
		.rdata     (fifo_rdata),
		.pop       (fifo_pop),
		.gpio      (gpio),
		.pad_state (pad_state)
	);

	blinky i_blinky (
		.clk_sys (clk_sys),
		.rst_n   (sys_rst_n),
		.blink   (blink)
	);

	// LEDs are active low; top bit shows the receive line's idle level
	assign rx_line_n = !uart_rx;

	assign led = ~{
		!rx_line_n,
		rx_line_n,
		4'h0,
		blink,
		pad_state.padout[`PIN_LED] && pad_state.padoe[`PIN_LED]
	};

endmodule

// ==== sim/board_sva.sv ====
// FIFO occupancy and internal reset release assertions, bound into byte_fifo

`timescale 1ns/1ps

`include "board_config.svh"

module board_sva (
	input logic                           clk_sys,
	input logic                           sys_rst_n,
	input logic                           push,
	input logic                           full,
	input logic                           empty,
	input logic [$clog2(`FIFO_DEPTH)-1:0] wr_ptr
);

	int fail_count = 0;

	// A push into a full FIFO writes nothing
	assert property (@(posedge clk_sys) disable iff (sys_rst_n !== 1'b1)
		push && full |=> $stable(wr_ptr))
		else begin
			fail_count++;
			$error("FIFO write pointer moved on a push while full");
		end

	assert property (@(posedge clk_sys) disable iff (sys_rst_n !== 1'b1)
		!(empty && full))
		else begin
			fail_count++;
			$error("FIFO empty and full both high");
		end

	// Internal reset holds for at least the release count
	assert property (@(posedge clk_sys)
		$fell(sys_rst_n) |-> !sys_rst_n [*`RESET_COUNT])
		else begin
			fail_count++;
			$error("Internal reset released too early");
		end

endmodule

// The FIFO runs on the internal reset, which is the one the release check watches
bind byte_fifo board_sva i_fifo_sva (
	.clk_sys   (clk_sys),
	.sys_rst_n (rst_n),
	.push      (push),
	.full      (full),
	.empty     (empty),
	.wr_ptr    (wr_ptr)
);

// ==== sim/board_tb.sv ====
// Testbench board_tb with clock, reset, serial byte driver, command table, checks and timeout

`timescale 1ns/1ps

`include "board_config.svh"

module board_tb;

	// One table row with command byte, stop bit fault, expected pads and LEDs
	typedef struct packed {
		logic [7:0]         cmd;
		logic               bad_stop;
		logic [`N_PADS-1:0] exp_gpio;
		logic [7:0]         exp_led;
	} row_t;

	localparam int N_ROWS = 17;
	localparam int TIMEOUT = N_ROWS * 14 * `BAUD_DIV + 200;

	// Active-low LED words with the line idle high
	localparam logic [7:0] LED_IDLE       = 8'h7F;
	localparam logic [7:0] LED_PIN_ON     = 8'h7E;
	// Bit 1 carries the blinker and stays out of the table compare
	localparam logic [7:0] LED_CHECK_MASK = 8'hFD;

	logic              clk_sys;
	logic              rst_n;
	logic              uart_rx;
	wire [`N_PADS-1:0] gpio;
	logic [7:0]        led;

	row_t   rows [N_ROWS];
	integer seed;
	int     errors;
	int     checks;
	int     sva_fails;
	int     cycles = 0;

	board_top i_board_top (
		.clk_sys (clk_sys),
		.rst_n   (rst_n),
		.uart_rx (uart_rx),
		.gpio    (gpio),
		.led     (led)
	);

	// Weak pulldowns so a released pad reads 0
	for (genvar i = 0; i < `N_PADS; i++) begin : g_pull
		pulldown pd_gpio (gpio[i]);
	end

	always #10 clk_sys = !clk_sys;

	always @(posedge clk_sys) begin
		cycles <= cycles + 1;
		if (cycles >= TIMEOUT) begin
			$display("Timeout after %0d cycles, the command sequence did not finish", cycles);
			$display("Testbench failed");
			$finish;
		end
	end

	function automatic logic [7:0] pin_cmd(input logic [1:0] op, input logic [2:0] pin,
			input logic value);
		return {op, pin, value, 2'b00};
	endfunction

	function automatic logic [7:0] mask_cmd(input logic [1:0] op, input logic [5:0] mask);
		return {op, mask};
	endfunction

	function automatic row_t make_row(input logic [7:0] cmd, input logic bad_stop,
			input logic [5:0] exp_gpio, input logic [7:0] exp_led);
		row_t r;
		r.cmd      = cmd;
		r.bad_stop = bad_stop;
		r.exp_gpio = exp_gpio;
		r.exp_led  = exp_led;
		return r;
	endfunction

	// Random masks first, then fixed pin, LED and framing rows on a known state
	task automatic fill_table;
		logic [5:0] m_oe;
		logic [5:0] m_out_a;
		logic [5:0] m_out_b;
		m_oe    = 6'($random(seed));
		m_out_a = 6'($random(seed));
		m_out_b = 6'($random(seed));
		rows[0]  = make_row(mask_cmd(2'd3, m_oe), 1'b0, 6'h00, LED_IDLE);
		rows[1]  = make_row(mask_cmd(2'd2, m_out_a), 1'b0, m_out_a & m_oe, LED_IDLE);
		rows[2]  = make_row(mask_cmd(2'd2, m_out_b), 1'b0, m_out_b & m_oe, LED_IDLE);
		rows[3]  = make_row(mask_cmd(2'd3, 6'h3F), 1'b0, m_out_b, LED_IDLE);
		rows[4]  = make_row(mask_cmd(2'd2, 6'h00), 1'b0, 6'h00, LED_IDLE);
		rows[5]  = make_row(mask_cmd(2'd2, 6'h2A), 1'b0, 6'h2A, LED_IDLE);
		rows[6]  = make_row(pin_cmd(2'd0, 3'd0, 1'b1), 1'b0, 6'h2B, LED_IDLE);
		rows[7]  = make_row(pin_cmd(2'd0, 3'd3, 1'b0), 1'b0, 6'h23, LED_IDLE);
		rows[8]  = make_row(pin_cmd(2'd1, 3'd5, 1'b0), 1'b0, 6'h03, LED_IDLE);
		// Pin 7 has no register
		rows[9]  = make_row(pin_cmd(2'd0, 3'd7, 1'b1), 1'b0, 6'h03, LED_IDLE);
		rows[10] = make_row(pin_cmd(2'd1, 3'd7, 1'b1), 1'b0, 6'h03, LED_IDLE);
		rows[11] = make_row(pin_cmd(2'd0, 3'd6, 1'b1), 1'b0, 6'h03, LED_IDLE);
		rows[12] = make_row(pin_cmd(2'd1, 3'd6, 1'b1), 1'b0, 6'h03, LED_PIN_ON);
		rows[13] = make_row(mask_cmd(2'd3, 6'h00), 1'b0, 6'h00, LED_PIN_ON);
		rows[14] = make_row(mask_cmd(2'd3, 6'h3F), 1'b1, 6'h00, LED_PIN_ON);
		rows[15] = make_row(mask_cmd(2'd3, 6'h3F), 1'b0, 6'h23, LED_PIN_ON);
		rows[16] = make_row(pin_cmd(2'd1, 3'd6, 1'b0), 1'b0, 6'h23, LED_IDLE);
	endtask

	// Start bit, 8 data bits LSB first, stop bit, each BAUD_DIV cycles long
	task automatic send_frame(input logic [7:0] data, input logic bad_stop);
		logic [9:0] frame;
		frame = {!bad_stop, data, 1'b0};
		for (int i = 0; i < 10; i++) begin
			@(negedge clk_sys);
			uart_rx = frame[i];
			repeat (`BAUD_DIV - 1) @(negedge clk_sys);
		end
		@(negedge clk_sys);
		uart_rx = 1'b1;
	endtask

	task automatic compare_outputs(input string what, input logic [5:0] exp_gpio,
			input logic [7:0] exp_led);
		checks++;
		assert (gpio === exp_gpio) else begin
			errors++;
			$display("MISMATCH %s gpio: expected %h, got %h", what, exp_gpio, gpio);
		end
		assert ((led & LED_CHECK_MASK) === (exp_led & LED_CHECK_MASK)) else begin
			errors++;
			$display("MISMATCH %s led: expected %h, got %h (bit 1 ignored)", what,
				exp_led, led);
		end
	endtask

	// Counts blink toggles regardless of phase
	task automatic watch_blink;
		int   toggles;
		logic prev;
		toggles = 0;
		prev    = led[1];
		repeat (4 * `BLINK_DIV) begin
			@(negedge clk_sys);
			if (led[1] !== prev)
				toggles++;
			prev = led[1];
		end
		checks++;
		assert (toggles >= 2) else begin
			errors++;
			$display("Blink LED toggled only %0d times in %0d cycles", toggles,
				4 * `BLINK_DIV);
		end
	endtask

	initial begin
		clk_sys   = 1'b0;
		rst_n     = 1'b0;
		uart_rx   = 1'b1;
		errors    = 0;
		checks    = 0;
		sva_fails = 0;
		seed      = 32'ha833;
		fill_table();
		repeat (8) @(negedge clk_sys);
		rst_n = 1'b1;
		repeat (`RESET_COUNT + 8) @(negedge clk_sys);
		compare_outputs("after reset", 6'h00, LED_IDLE);
		checks++;
		assert (led === LED_IDLE) else begin
			errors++;
			$display("MISMATCH after reset led: expected %h, got %h", LED_IDLE, led);
		end
		for (int i = 0; i < N_ROWS; i++) begin
			send_frame(rows[i].cmd, rows[i].bad_stop);
			repeat (3 * `BAUD_DIV) @(negedge clk_sys);
			compare_outputs($sformatf("row %0d", i), rows[i].exp_gpio, rows[i].exp_led);
		end
		watch_blink();
		sva_fails = i_board_top.i_byte_fifo.i_fifo_sva.fail_count;
		$display("Checks: %0d, errors: %0d, assertion failures: %0d",
			checks, errors, sva_fails);
		if (errors == 0 && sva_fails == 0)
			$display("Testbench passed");
		else
			$display("Testbench failed");
		$finish;
	end

endmodule

// ==== project.f ====
+incdir+common
common/board_pkg.sv
hdl/fpga_reset.sv
uart/uart_rx.sv
uart/byte_fifo.sv
hdl/pad_ctrl.sv
hdl/blinky.sv
hdl/board_top.sv
sim/board_sva.sv
sim/board_tb.sv

// ==== Bender.yml ====
package:
  name: board

sources:
  - include_dirs:
      - common
    files:
      - common/board_pkg.sv
      - hdl/fpga_reset.sv
      - uart/uart_rx.sv
      - uart/byte_fifo.sv
      - hdl/pad_ctrl.sv
      - hdl/blinky.sv
      - hdl/board_top.sv
  - target: simulation
    include_dirs:
      - common
    files:
      - sim/board_sva.sv
      - sim/board_tb.sv
